// File: design/kbd_types_pkg.sv
package kbd_types_pkg;

    // One data byte as received from the keyboard
    typedef logic [7:0] ps2_byte_t;

    // Translated virtual key code
    typedef logic [7:0] vk_code_t;

    // Queued key event, release flag on top of the vk code
    typedef logic [8:0] kbd_event_t;

endpackage

// File: design/kbd_codes_pkg.sv
package kbd_codes_pkg;

    import kbd_types_pkg::*;

    // Scan-code set 2 prefixes
    localparam ps2_byte_t PS2_PREFIX_EXT   = 8'hE0;
    localparam ps2_byte_t PS2_PREFIX_BREAK = 8'hF0;

    // Unmapped keys
    localparam vk_code_t VK_NONE = 8'h00;

    // Letters and digits are contiguous from these bases
    localparam vk_code_t VK_A = 8'h41;
    localparam vk_code_t VK_0 = 8'h30;

    localparam vk_code_t VK_BKSP  = 8'h08;
    localparam vk_code_t VK_ENTER = 8'h0D;
    localparam vk_code_t VK_ESC   = 8'h1B;
    localparam vk_code_t VK_SPACE = 8'h20;

    // Extended arrow keys
    localparam vk_code_t VK_LEFT  = 8'h25;
    localparam vk_code_t VK_UP    = 8'h26;
    localparam vk_code_t VK_RIGHT = 8'h27;
    localparam vk_code_t VK_DOWN  = 8'h28;

endpackage

// File: design/scan_event_if.sv
interface scan_event_if
    import kbd_types_pkg::*;
();

    // One-cycle strobe, the sink always takes it
    logic      valid;
    // Key was preceded by E0
    logic      extended;
    // Key was preceded by F0
    logic      is_break;
    ps2_byte_t code;

    modport source (
        output valid,
        output extended,
        output is_break,
        output code
    );

    modport sink (
        input valid,
        input extended,
        input is_break,
        input code
    );

endinterface

// File: design/ps2_rx.sv
module ps2_rx
    import kbd_types_pkg::*;
#(
    parameter int FILTER_LEN = 4
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      ps2_clk_i,
    input  logic      ps2_data_i,
    output ps2_byte_t byte_o,
    output logic      byte_valid_o
);

    localparam int CNT_W     = $clog2(FILTER_LEN + 1);
    localparam int LINE_CLK  = 0;
    localparam int LINE_DATA = 1;

    logic [1:0]       line_async;
    logic [1:0]       sync_meta_q;
    logic [1:0]       sync_q;
    logic [1:0]       filt_q;
    logic [CNT_W-1:0] filt_cnt_q [2];

    logic             clk_prev_q;
    logic             clk_fall;
    logic [10:0]      frame_q;
    logic [3:0]       bit_cnt_q;
    logic             frame_done_q;
    logic             frame_ok;

    assign line_async = {ps2_data_i, ps2_clk_i};

    // Both lines get the same synchronizer and glitch filter
    for (genvar i = 0; i < 2; i++) begin : g_line
        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                sync_meta_q[i] <= 1'b1;
                sync_q[i]      <= 1'b1;
            end else begin
                sync_meta_q[i] <= line_async[i];
                sync_q[i]      <= sync_meta_q[i];
            end
        end

        // New level is taken after FILTER_LEN samples in a row
        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                filt_q[i]     <= 1'b1;
                filt_cnt_q[i] <= '0;
            end else if (sync_q[i] == filt_q[i]) begin
                filt_cnt_q[i] <= '0;
            end else if (filt_cnt_q[i] == CNT_W'(FILTER_LEN - 1)) begin
                filt_q[i]     <= sync_q[i];
                filt_cnt_q[i] <= '0;
            end else begin
                filt_cnt_q[i] <= filt_cnt_q[i] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            clk_prev_q <= 1'b1;
        end else begin
            clk_prev_q <= filt_q[LINE_CLK];
        end
    end

    // Keyboard changes data while its clock is high, so sample on the fall
    assign clk_fall = clk_prev_q && !filt_q[LINE_CLK];

    // LSB first, start bit ends up in bit 0
    always_ff @(posedge clk_i) begin
        if (clk_fall) begin
            frame_q <= {filt_q[LINE_DATA], frame_q[10:1]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bit_cnt_q    <= '0;
            frame_done_q <= 1'b0;
        end else begin
            frame_done_q <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt_q == 4'd10) begin
                    bit_cnt_q    <= '0;
                    frame_done_q <= 1'b1;
                end else begin
                    bit_cnt_q <= bit_cnt_q + 4'd1;
                end
            end
        end
    end

    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok = !frame_q[0] && frame_q[10] && (^frame_q[9:1]);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= frame_done_q && frame_ok;
        end
    end

    always_ff @(posedge clk_i) begin
        if (frame_done_q) begin
            byte_o <= frame_q[8:1];
        end
    end

    // Frames are far apart, so a strobe never repeats back to back
    a_single_strobe: assert property (
        @(posedge clk_i) disable iff (rst_i) byte_valid_o |=> !byte_valid_o
    );

endmodule

// File: design/ps2_scan_decoder.sv
module ps2_scan_decoder
    import kbd_types_pkg::*;
    import kbd_codes_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  ps2_byte_t    byte_i,
    input  logic         byte_valid_i,
    scan_event_if.source evt
);

    typedef enum logic [1:0] {
        IDLE,
        GOT_EXT,
        GOT_BREAK,
        GOT_EXT_BREAK
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   ext_flag;
    logic   break_flag;
    logic   is_prefix;
    logic   key_done;

    assign ext_flag   = (state_q == GOT_EXT) || (state_q == GOT_EXT_BREAK);
    assign break_flag = (state_q == GOT_BREAK) || (state_q == GOT_EXT_BREAK);
    assign is_prefix  = (byte_i == PS2_PREFIX_EXT) || (byte_i == PS2_PREFIX_BREAK);
    assign key_done   = byte_valid_i && !is_prefix;

    // Prefixes add a flag, anything else ends the sequence
    always_comb begin
        state_d = state_q;
        if (byte_valid_i) begin
            if (byte_i == PS2_PREFIX_EXT) begin
                state_d = break_flag ? GOT_EXT_BREAK : GOT_EXT;
            end else if (byte_i == PS2_PREFIX_BREAK) begin
                state_d = ext_flag ? GOT_EXT_BREAK : GOT_BREAK;
            end else begin
                state_d = IDLE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= IDLE;
            evt.valid <= 1'b0;
        end else begin
            state_q   <= state_d;
            evt.valid <= key_done;
        end
    end

    // Flags are those collected before the final byte
    always_ff @(posedge clk_i) begin
        if (key_done) begin
            evt.code     <= byte_i;
            evt.extended <= ext_flag;
            evt.is_break <= break_flag;
        end
    end

    a_no_prefix_event: assert property (
        @(posedge clk_i) disable iff (rst_i)
        evt.valid |-> (evt.code != PS2_PREFIX_EXT) && (evt.code != PS2_PREFIX_BREAK)
    );

endmodule

// File: design/keycode_rom.sv
module keycode_rom
    import kbd_types_pkg::*;
    import kbd_codes_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    scan_event_if.sink evt,
    output kbd_event_t wr_event_o,
    output logic       wr_valid_o
);

    logic [8:0] key;
    vk_code_t   vk_d;

    assign key = {evt.extended, evt.code};

    always_comb begin
        case (key)
            // Letters A to Z
            {1'b0, 8'h1C}: vk_d = VK_A + 8'd0;
            {1'b0, 8'h32}: vk_d = VK_A + 8'd1;
            {1'b0, 8'h21}: vk_d = VK_A + 8'd2;
            {1'b0, 8'h23}: vk_d = VK_A + 8'd3;
            {1'b0, 8'h24}: vk_d = VK_A + 8'd4;
            {1'b0, 8'h2B}: vk_d = VK_A + 8'd5;
            {1'b0, 8'h34}: vk_d = VK_A + 8'd6;
            {1'b0, 8'h33}: vk_d = VK_A + 8'd7;
            {1'b0, 8'h43}: vk_d = VK_A + 8'd8;
            {1'b0, 8'h3B}: vk_d = VK_A + 8'd9;
            {1'b0, 8'h42}: vk_d = VK_A + 8'd10;
            {1'b0, 8'h4B}: vk_d = VK_A + 8'd11;
            {1'b0, 8'h3A}: vk_d = VK_A + 8'd12;
            {1'b0, 8'h31}: vk_d = VK_A + 8'd13;
            {1'b0, 8'h44}: vk_d = VK_A + 8'd14;
            {1'b0, 8'h4D}: vk_d = VK_A + 8'd15;
            {1'b0, 8'h15}: vk_d = VK_A + 8'd16;
            {1'b0, 8'h2D}: vk_d = VK_A + 8'd17;
            {1'b0, 8'h1B}: vk_d = VK_A + 8'd18;
            {1'b0, 8'h2C}: vk_d = VK_A + 8'd19;
            {1'b0, 8'h3C}: vk_d = VK_A + 8'd20;
            {1'b0, 8'h2A}: vk_d = VK_A + 8'd21;
            {1'b0, 8'h1D}: vk_d = VK_A + 8'd22;
            {1'b0, 8'h22}: vk_d = VK_A + 8'd23;
            {1'b0, 8'h35}: vk_d = VK_A + 8'd24;
            {1'b0, 8'h1A}: vk_d = VK_A + 8'd25;
            // Top row digits
            {1'b0, 8'h45}: vk_d = VK_0 + 8'd0;
            {1'b0, 8'h16}: vk_d = VK_0 + 8'd1;
            {1'b0, 8'h1E}: vk_d = VK_0 + 8'd2;
            {1'b0, 8'h26}: vk_d = VK_0 + 8'd3;
            {1'b0, 8'h25}: vk_d = VK_0 + 8'd4;
            {1'b0, 8'h2E}: vk_d = VK_0 + 8'd5;
            {1'b0, 8'h36}: vk_d = VK_0 + 8'd6;
            {1'b0, 8'h3D}: vk_d = VK_0 + 8'd7;
            {1'b0, 8'h3E}: vk_d = VK_0 + 8'd8;
            {1'b0, 8'h46}: vk_d = VK_0 + 8'd9;
            {1'b0, 8'h5A}: vk_d = VK_ENTER;
            {1'b0, 8'h76}: vk_d = VK_ESC;
            {1'b0, 8'h29}: vk_d = VK_SPACE;
            {1'b0, 8'h66}: vk_d = VK_BKSP;
            // Arrows only exist behind E0, plain codes are keypad keys
            {1'b1, 8'h6B}: vk_d = VK_LEFT;
            {1'b1, 8'h75}: vk_d = VK_UP;
            {1'b1, 8'h74}: vk_d = VK_RIGHT;
            {1'b1, 8'h72}: vk_d = VK_DOWN;
            default:       vk_d = VK_NONE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_valid_o <= 1'b0;
        end else begin
            wr_valid_o <= evt.valid;
        end
    end

    // Release flag travels with the code
    always_ff @(posedge clk_i) begin
        if (evt.valid) begin
            wr_event_o <= {evt.is_break, vk_d};
        end
    end

endmodule

// File: design/event_fifo.sv
module event_fifo
    import kbd_types_pkg::*;
#(
    parameter int FIFO_ADDR_W = 4
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  kbd_event_t wr_event_i,
    input  logic       wr_valid_i,
    output kbd_event_t rd_event_o,
    output logic       rd_valid_o,
    input  logic       rd_ready_i
);

    localparam int DEPTH = 1 << FIFO_ADDR_W;

    kbd_event_t           mem [DEPTH];
    logic [FIFO_ADDR_W:0] wr_ptr_q;
    logic [FIFO_ADDR_W:0] rd_ptr_q;
    logic [FIFO_ADDR_W:0] wr_ptr_d;
    logic [FIFO_ADDR_W:0] rd_ptr_d;
    logic [FIFO_ADDR_W:0] count;
    logic                 full;
    logic                 wr_en;
    logic                 rd_en;

    // Extra pointer bit tells full from empty
    assign count = wr_ptr_q - rd_ptr_q;
    assign full  = (count == (FIFO_ADDR_W + 1)'(DEPTH));
    assign wr_en = wr_valid_i && !full;
    assign rd_en = rd_valid_o && rd_ready_i;

    assign wr_ptr_d = wr_ptr_q + (FIFO_ADDR_W + 1)'(wr_en);
    assign rd_ptr_d = rd_ptr_q + (FIFO_ADDR_W + 1)'(rd_en);

    assign rd_valid_o = (wr_ptr_q != rd_ptr_q);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_d;
            rd_ptr_q <= rd_ptr_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr_q[FIFO_ADDR_W-1:0]] <= wr_event_i;
        end
    end

    // Head register loads the next head entry
    // Bypass the write when it lands straight at the head
    always_ff @(posedge clk_i) begin
        if (wr_en && (rd_ptr_d == wr_ptr_q)) begin
            rd_event_o <= wr_event_i;
        end else begin
            rd_event_o <= mem[rd_ptr_d[FIFO_ADDR_W-1:0]];
        end
    end

    a_no_overfill: assert property (
        @(posedge clk_i) disable iff (rst_i) count <= (FIFO_ADDR_W + 1)'(DEPTH)
    );

endmodule

// File: design/kbd_controller.sv
module kbd_controller
    import kbd_types_pkg::*;
#(
    parameter int FILTER_LEN  = 4,
    parameter int FIFO_ADDR_W = 4
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       ps2_clk_i,
    input  logic       ps2_data_i,
    output kbd_event_t event_o,
    output logic       event_valid_o,
    input  logic       event_ready_i,
    output logic       irq_o
);

    ps2_byte_t  rx_byte;
    logic       rx_byte_valid;
    kbd_event_t rom_event;
    logic       rom_valid;

    scan_event_if scan_evt ();

    ps2_rx #(
        .FILTER_LEN (FILTER_LEN)
    ) u_ps2_rx (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .ps2_clk_i    (ps2_clk_i),
        .ps2_data_i   (ps2_data_i),
        .byte_o       (rx_byte),
        .byte_valid_o (rx_byte_valid)
    );

    ps2_scan_decoder u_decoder (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .byte_i       (rx_byte),
        .byte_valid_i (rx_byte_valid),
        .evt          (scan_evt.source)
    );

    keycode_rom u_keycode_rom (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .evt        (scan_evt.sink),
        .wr_event_o (rom_event),
        .wr_valid_o (rom_valid)
    );

    event_fifo #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) u_event_fifo (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wr_event_i (rom_event),
        .wr_valid_i (rom_valid),
        .rd_event_o (event_o),
        .rd_valid_o (event_valid_o),
        .rd_ready_i (event_ready_i)
    );

    // Interrupt while anything is queued
    assign irq_o = event_valid_o;

endmodule

// File: tb/ps2_device_model.sv
module ps2_device_model (
    output logic ps2_clk_o,
    output logic ps2_data_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 us bit period, data settles a quarter period before the fall
    localparam int QUARTER_NS = 5000;
    localparam int GAP_NS     = 20000;

    // Both lines idle high, like a released open-collector bus
    logic clk_line  = 1'b1;
    logic data_line = 1'b1;

    assign ps2_clk_o  = clk_line;
    assign ps2_data_o = data_line;

    // Start, 8 data bits LSB first, odd parity, stop
    task automatic send_byte(input logic [7:0] data, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, ~^data ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            data_line = frame[i];
            #(QUARTER_NS);
            clk_line = 1'b0;
            #(2 * QUARTER_NS);
            clk_line = 1'b1;
            #(QUARTER_NS);
        end
        data_line = 1'b1;
        // Idle time before the next frame
        #(GAP_NS);
    endtask

endmodule

// File: tb/kbd_controller_tb.sv
module kbd_controller_tb
    import kbd_types_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIFO_DEPTH       = 16;
    localparam int CYCLES_PER_FRAME = 25000;
    localparam int QUIET_CYCLES     = 200;
    localparam int FILL_KEYS        = 20;
    localparam int RANDOM_KEYS      = 10;
    localparam int STALL_UNIT       = 20000;
    localparam int MAX_ROWS         = 32;

    // Set 2 make codes, A to Z and 0 to 9
    localparam logic [7:0] LETTER_SCAN [26] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A,
        8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
    };
    localparam logic [7:0] DIGIT_SCAN [10] = '{
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
    };

    logic        clk_i;
    logic        rst_i;
    logic        ps2_clk;
    logic        ps2_data;
    kbd_event_t  event_o;
    logic        event_valid_o;
    logic        event_ready_i;
    logic        irq_o;

    string       row_name [MAX_ROWS];
    int          row_len  [MAX_ROWS];
    logic [23:0] row_seq  [MAX_ROWS];
    logic [2:0]  row_bad  [MAX_ROWS];
    int          row_count;
    int          cycle_count;
    int          cycle_limit;
    integer      seed;

    kbd_controller #(
        .FILTER_LEN  (4),
        .FIFO_ADDR_W (4)
    ) DUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .ps2_clk_i     (ps2_clk),
        .ps2_data_i    (ps2_data),
        .event_o       (event_o),
        .event_valid_o (event_valid_o),
        .event_ready_i (event_ready_i),
        .irq_o         (irq_o)
    );

    ps2_device_model kbd (
        .ps2_clk_o  (ps2_clk),
        .ps2_data_o (ps2_data)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("Timeout: run did not finish in %0d cycles", cycle_count));
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("Error: %s expected %0h actual %0h",
                                        name, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic pop_event();
        event_ready_i = 1'b1;
        next_cycle();
        event_ready_i = 1'b0;
    endtask

    task automatic wait_for_event();
        int waited;
        waited = 0;
        next_cycle();
        while (!event_valid_o && waited < QUIET_CYCLES) begin
            next_cycle();
            waited++;
        end
    endtask

    // Virtual key values for each scan code
    function automatic logic [7:0] translate_key(input logic ext, input logic [7:0] code);
        logic [7:0] vk;
        vk = 8'h00;
        if (ext) begin
            if (code == 8'h6B) vk = 8'h25;
            else if (code == 8'h75) vk = 8'h26;
            else if (code == 8'h74) vk = 8'h27;
            else if (code == 8'h72) vk = 8'h28;
        end else begin
            for (int i = 0; i < 26; i++) begin
                if (LETTER_SCAN[i] == code) vk = 8'h41 + 8'(i);
            end
            for (int i = 0; i < 10; i++) begin
                if (DIGIT_SCAN[i] == code) vk = 8'h30 + 8'(i);
            end
            if (code == 8'h5A) vk = 8'h0D;
            else if (code == 8'h76) vk = 8'h1B;
            else if (code == 8'h29) vk = 8'h20;
            else if (code == 8'h66) vk = 8'h08;
        end
        return vk;
    endfunction

    // Bad frames vanish, E0 and F0 only set flags for the next code
    function automatic void predict_event(input int r, output logic has_evt,
                                          output kbd_event_t evt);
        logic       ext;
        logic       brk;
        logic [7:0] b;
        ext     = 1'b0;
        brk     = 1'b0;
        has_evt = 1'b0;
        evt     = '0;
        for (int i = 0; i < row_len[r]; i++) begin
            b = row_seq[r][8*i +: 8];
            if (!row_bad[r][i]) begin
                if (b == 8'hE0) begin
                    ext = 1'b1;
                end else if (b == 8'hF0) begin
                    brk = 1'b1;
                end else begin
                    has_evt = 1'b1;
                    evt     = {brk, translate_key(ext, b)};
                    ext     = 1'b0;
                    brk     = 1'b0;
                end
            end
        end
    endfunction

    task automatic add_row(input string name, input int len, input logic [7:0] b0,
                           input logic [7:0] b1, input logic [7:0] b2, input logic [2:0] bad);
        row_name[row_count] = name;
        row_len[row_count]  = len;
        row_seq[row_count]  = {b2, b1, b0};
        row_bad[row_count]  = bad;
        row_count++;
    endtask

    task automatic build_table();
        add_row("make A",       1, 8'h1C, 8'h00, 8'h00, 3'b000);
        add_row("make Z",       1, 8'h1A, 8'h00, 8'h00, 3'b000);
        add_row("make M",       1, 8'h3A, 8'h00, 8'h00, 3'b000);
        add_row("make 0",       1, 8'h45, 8'h00, 8'h00, 3'b000);
        add_row("make 5",       1, 8'h2E, 8'h00, 8'h00, 3'b000);
        add_row("make 9",       1, 8'h46, 8'h00, 8'h00, 3'b000);
        add_row("make enter",   1, 8'h5A, 8'h00, 8'h00, 3'b000);
        add_row("make esc",     1, 8'h76, 8'h00, 8'h00, 3'b000);
        add_row("make space",   1, 8'h29, 8'h00, 8'h00, 3'b000);
        add_row("make bksp",    1, 8'h66, 8'h00, 8'h00, 3'b000);
        add_row("unmapped",     1, 8'h0E, 8'h00, 8'h00, 3'b000);
        add_row("break A",      2, 8'hF0, 8'h1C, 8'h00, 3'b000);
        add_row("break enter",  2, 8'hF0, 8'h5A, 8'h00, 3'b000);
        add_row("ext up",       2, 8'hE0, 8'h75, 8'h00, 3'b000);
        add_row("ext left",     2, 8'hE0, 8'h6B, 8'h00, 3'b000);
        add_row("ext right",    2, 8'hE0, 8'h74, 8'h00, 3'b000);
        add_row("ext down",     2, 8'hE0, 8'h72, 8'h00, 3'b000);
        add_row("ext up break", 3, 8'hE0, 8'hF0, 8'h75, 3'b000);
        add_row("plain 75",     1, 8'h75, 8'h00, 8'h00, 3'b000);
        add_row("ext unmapped", 2, 8'hE0, 8'h1C, 8'h00, 3'b000);
        add_row("bad parity",   1, 8'h1C, 8'h00, 8'h00, 3'b001);
        add_row("after bad",    1, 8'h32, 8'h00, 8'h00, 3'b000);
    endtask

    task automatic play_row(input int r);
        logic       has_evt;
        kbd_event_t expected;
        predict_event(r, has_evt, expected);
        for (int i = 0; i < row_len[r]; i++) begin
            kbd.send_byte(row_seq[r][8*i +: 8], row_bad[r][i]);
        end
        wait_for_event();
        check_value({row_name[r], " valid"}, 32'(has_evt), 32'(event_valid_o));
        if (has_evt) begin
            check_value(row_name[r], 32'(expected), 32'(event_o));
            pop_event();
        end
    endtask

    task automatic check_idle();
        check_value("reset valid", 32'd0, 32'(event_valid_o));
        check_value("reset irq", 32'd0, 32'(irq_o));
        repeat (1000) next_cycle();
        check_value("idle valid", 32'd0, 32'(event_valid_o));
        check_value("idle irq", 32'd0, 32'(irq_o));
    endtask

    // Host holds ready low, only the first FIFO_DEPTH keys fit
    task automatic run_fill_test();
        kbd_event_t expected;
        event_ready_i = 1'b0;
        for (int k = 0; k < FILL_KEYS; k++) begin
            kbd.send_byte(LETTER_SCAN[k], 1'b0);
        end
        next_cycle();
        for (int k = 0; k < FIFO_DEPTH; k++) begin
            expected = {1'b0, translate_key(1'b0, LETTER_SCAN[k])};
            check_value($sformatf("fill irq %0d", k), 32'd1, 32'(irq_o));
            check_value($sformatf("fill valid %0d", k), 32'd1, 32'(event_valid_o));
            check_value($sformatf("fill key %0d", k), 32'(expected), 32'(event_o));
            pop_event();
        end
        check_value("fill empty valid", 32'd0, 32'(event_valid_o));
        check_value("fill empty irq", 32'd0, 32'(irq_o));
    endtask

    task automatic run_random_stalls();
        logic [31:0] r;
        kbd_event_t  expected;
        fork
            begin
                for (int k = 0; k < RANDOM_KEYS; k++) begin
                    kbd.send_byte(DIGIT_SCAN[k], 1'b0);
                end
            end
            begin
                for (int k = 0; k < RANDOM_KEYS; k++) begin
                    next_cycle();
                    while (!event_valid_o) begin
                        next_cycle();
                    end
                    expected = {1'b0, translate_key(1'b0, DIGIT_SCAN[k])};
                    check_value($sformatf("stall key %0d", k), 32'(expected), 32'(event_o));
                    r = $random(seed);
                    repeat (int'(r[1:0]) * STALL_UNIT) next_cycle();
                    pop_event();
                end
            end
        join
        next_cycle();
        check_value("stall empty valid", 32'd0, 32'(event_valid_o));
    endtask

    initial begin
        seed          = 32'h6f93_3c38;
        rst_i         = 1'b1;
        event_ready_i = 1'b0;
        build_table();
        // Three frames per row, reader stalls up to three frames per key
        cycle_limit = (row_count * 3 + FILL_KEYS + RANDOM_KEYS * 4) * CYCLES_PER_FRAME + 20000;
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check_idle();
        for (int r = 0; r < row_count; r++) begin
            play_row(r);
        end
        run_fill_test();
        run_random_stalls();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: filelist.f
design/kbd_types_pkg.sv
design/kbd_codes_pkg.sv
design/scan_event_if.sv
design/ps2_rx.sv
design/ps2_scan_decoder.sv
design/keycode_rom.sv
design/event_fifo.sv
design/kbd_controller.sv
tb/ps2_device_model.sv
tb/kbd_controller_tb.sv

// File: Makefile
TOP := kbd_controller_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module kbd_controller -f filelist.f

clean:
	rm -rf obj_dir
